//--- design/core_pkg.sv
/*
 * Datapath widths and word types of the scalar core.
 * Imported by the register file, the execute unit, the program counter
 * and the top level.
 */

package core_pkg;

	localparam int DATA_WIDTH = 32;
	localparam int REG_IDX_WIDTH = 4;
	localparam int PC_WIDTH = 8;
	localparam int INSTR_WIDTH = 32;

	// Register count follows from the index width
	localparam int NUM_REGS = 1 << REG_IDX_WIDTH;

	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;
	typedef logic [PC_WIDTH-1:0] pc_t;
	typedef logic [INSTR_WIDTH-1:0] instr_t;

endpackage

//--- design/exec_unit.sv
/*
 * Execute unit: instruction register, field decode, integer ALU and
 * branch decision. The ALU value lands in the result register at the
 * end of the execute phase and stays there through write-back.
 */

`timescale 1ns/10ps

module exec_unit (
	input	logic				clock,
	input	logic				reset,
	input	logic				instr_capture,
	input	logic				result_capture,
	input	core_pkg::instr_t	imem_data,
	input	core_pkg::data_t	rdata1,
	input	core_pkg::data_t	rdata2,
	output	core_pkg::reg_idx_t	raddr1,
	output	core_pkg::reg_idx_t	raddr2,
	output	core_pkg::reg_idx_t	dst,
	output	core_pkg::data_t	result,
	output	core_pkg::pc_t		target,
	output	logic				writes_reg,
	output	logic				branch_taken,
	output	logic				is_halt
);

	import core_pkg::*;
	import isa_pkg::*;

	instr_t instr_q;
	data_t result_q;
	opcode_t opcode;
	logic [IMM_WIDTH-1:0] imm;
	data_t imm_sext;
	data_t imm_zext;
	logic [SHAMT_WIDTH-1:0] shamt;
	data_t alu;

	always_ff @(posedge clock) begin
		if (reset) begin
			instr_q <= '0;
		end else if (instr_capture) begin
			instr_q <= imem_data;
		end
	end

	//////////////////////////////
	// Decode
	//////////////////////////////
	assign opcode = instr_q[OPC_LSB +: $bits(opcode_t)];
	assign dst = instr_q[DST_LSB +: $bits(reg_idx_t)];
	assign raddr1 = instr_q[SRC1_LSB +: $bits(reg_idx_t)];
	assign raddr2 = instr_q[SRC2_LSB +: $bits(reg_idx_t)];
	assign imm = instr_q[IMM_LSB +: IMM_WIDTH];
	assign imm_sext = {{(DATA_WIDTH-IMM_WIDTH){imm[IMM_WIDTH-1]}}, imm};
	assign imm_zext = {{(DATA_WIDTH-IMM_WIDTH){1'b0}}, imm};
	assign shamt = rdata2[SHAMT_WIDTH-1:0];
	assign target = imm[$bits(pc_t)-1:0];

	//////////////////////////////
	// ALU
	//////////////////////////////
	always_comb begin
		alu = '0;
		writes_reg = 1'b1;
		case (opcode)
			OP_ADD:		alu = rdata1 + rdata2;
			OP_SUB:		alu = rdata1 - rdata2;
			OP_AND:		alu = rdata1 & rdata2;
			OP_OR:		alu = rdata1 | rdata2;
			OP_XOR:		alu = rdata1 ^ rdata2;
			OP_SHL:		alu = rdata1 << shamt;
			OP_SHR:		alu = rdata1 >> shamt;
			OP_ADDI:	alu = rdata1 + imm_sext;
			OP_MOVI:	alu = imm_zext;
			default:	writes_reg = 1'b0;
		endcase
	end

	// Decision is needed inside execute to steer the counter
	assign branch_taken = (opcode == OP_JMP) || (opcode == OP_BEQ && rdata1 == rdata2);
	assign is_halt = (opcode == OP_HALT);

	always_ff @(posedge clock) begin
		if (reset) begin
			result_q <= '0;
		end else if (result_capture) begin
			result_q <= alu;
		end
	end

	assign result = result_q;

endmodule

//--- design/isa_pkg.sv
/*
 * Instruction set of the scalar core: field positions, opcode type
 * and opcode values. Opcodes outside 0 to 11 execute as no-operations.
 */

package isa_pkg;

	typedef logic [3:0] opcode_t;

	//////////////////////////////
	// Field positions from the MSB down
	//////////////////////////////
	localparam int OPC_LSB = 28;
	localparam int DST_LSB = 24;
	localparam int SRC1_LSB = 20;
	localparam int SRC2_LSB = 16;
	localparam int IMM_LSB = 0;
	localparam int IMM_WIDTH = 16;

	// Shift amount taken from the low bits of src2
	localparam int SHAMT_WIDTH = 5;

	//////////////////////////////
	// Opcodes
	//////////////////////////////
	localparam opcode_t OP_ADD = 4'd0;
	localparam opcode_t OP_SUB = 4'd1;
	localparam opcode_t OP_AND = 4'd2;
	localparam opcode_t OP_OR = 4'd3;
	localparam opcode_t OP_XOR = 4'd4;
	localparam opcode_t OP_SHL = 4'd5;
	localparam opcode_t OP_SHR = 4'd6;
	localparam opcode_t OP_ADDI = 4'd7;
	localparam opcode_t OP_MOVI = 4'd8;
	localparam opcode_t OP_BEQ = 4'd9;
	localparam opcode_t OP_JMP = 4'd10;
	localparam opcode_t OP_HALT = 4'd11;

endpackage

//--- design/prog_counter.sv
/*
 * Program address counter. Loads the start address when a run begins,
 * steps by one after each instruction, or takes a branch target.
 */

`timescale 1ns/10ps

module prog_counter #(
	parameter core_pkg::pc_t START_ADDR = '0
) (
	input	logic			clock,
	input	logic			reset,
	input	logic			pc_start,
	input	logic			pc_advance,
	input	logic			pc_load,
	input	core_pkg::pc_t	target,
	output	core_pkg::pc_t	pc
);

	import core_pkg::*;

	pc_t pc_next;

	// Wraps from 255 back to 0
	always_comb begin
		pc_next = pc;
		if (pc_start) begin
			pc_next = START_ADDR;
		end else if (pc_load) begin
			pc_next = target;
		end else if (pc_advance) begin
			pc_next = pc + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= '0;
		end else begin
			pc <= pc_next;
		end
	end

	assert property (@(posedge clock) disable iff (reset) !(pc_advance && pc_load));

endmodule

//--- design/reg_file.sv
/*
 * Scalar register file with two combinational read ports and one
 * write port. Register 0 is hardwired to zero.
 */

`timescale 1ns/10ps

module reg_file (
	input	logic				clock,
	input	logic				reset,
	input	logic				we,
	input	core_pkg::reg_idx_t	waddr,
	input	core_pkg::data_t	wdata,
	input	core_pkg::reg_idx_t	raddr1,
	input	core_pkg::reg_idx_t	raddr2,
	output	core_pkg::data_t	rdata1,
	output	core_pkg::data_t	rdata2
);

	import core_pkg::*;

	// No storage behind r0
	data_t regs [1:NUM_REGS-1];

	function automatic data_t read_port(input reg_idx_t addr);
		if (addr == '0) begin
			return '0;
		end
		return regs[addr];
	endfunction

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 1; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = read_port(raddr1);
	assign rdata2 = read_port(raddr2);

endmodule

//--- design/run_ctrl.sv
/*
 * Phase sequencer of the scalar core. Steps one instruction at a time
 * through fetch, decode, execute and an optional write-back, and parks
 * in a halted phase after HALT until reset.
 */

`timescale 1ns/10ps

module run_ctrl (
	input	logic	clock,
	input	logic	reset,
	input	logic	start,
	input	logic	writes_reg,
	input	logic	branch_taken,
	input	logic	is_halt,
	input	logic	wb_ready,
	output	logic	imem_re,
	output	logic	instr_capture,
	output	logic	result_capture,
	output	logic	pc_start,
	output	logic	pc_advance,
	output	logic	pc_load,
	output	logic	wb_valid,
	output	logic	halted
);

	typedef enum logic [2:0] {
		IDLE,
		FETCH,
		DECODE,
		EXECUTE,
		WRITE,
		HALTED
	} phase_t;

	phase_t phase;
	phase_t phase_next;

	always_ff @(posedge clock) begin
		if (reset) begin
			phase <= IDLE;
		end else begin
			phase <= phase_next;
		end
	end

	//////////////////////////////
	// Strobes and next phase
	//////////////////////////////
	always_comb begin
		phase_next = phase;
		imem_re = 1'b0;
		instr_capture = 1'b0;
		result_capture = 1'b0;
		pc_start = 1'b0;
		pc_advance = 1'b0;
		pc_load = 1'b0;
		wb_valid = 1'b0;
		halted = 1'b0;
		case (phase)
			IDLE: begin
				pc_start = start;
				if (start) begin
					phase_next = FETCH;
				end
			end
			FETCH: begin
				imem_re = 1'b1;
				phase_next = DECODE;
			end
			DECODE: begin
				instr_capture = 1'b1;
				phase_next = EXECUTE;
			end
			EXECUTE: begin
				result_capture = 1'b1;
				if (is_halt) begin
					phase_next = HALTED;
				end else if (writes_reg) begin
					phase_next = WRITE;
				end else begin
					// Branches, jumps and no-ops go straight back to fetch
					pc_load = branch_taken;
					pc_advance = !branch_taken;
					phase_next = FETCH;
				end
			end
			WRITE: begin
				wb_valid = 1'b1;
				if (wb_ready) begin
					pc_advance = 1'b1;
					phase_next = FETCH;
				end
			end
			HALTED: begin
				halted = 1'b1;
			end
			default: begin
				phase_next = IDLE;
			end
		endcase
	end

	// A pending record is never withdrawn
	assert property (@(posedge clock) disable iff (reset)
		wb_valid && !wb_ready |=> wb_valid);

endmodule

//--- design/scalar_core.sv
/*
 * Top level of the multicycle scalar core. Fetches from an external
 * instruction memory with a one-cycle read, executes one instruction
 * at a time and streams every register write out through valid/ready.
 */

`timescale 1ns/10ps

module scalar_core #(
	parameter core_pkg::pc_t START_ADDR = '0
) (
	input	logic				clock,
	input	logic				reset,
	input	logic				start,
	output	logic				imem_re,
	output	core_pkg::pc_t		imem_addr,
	input	core_pkg::instr_t	imem_data,
	output	logic				wb_valid,
	input	logic				wb_ready,
	output	core_pkg::reg_idx_t	wb_index,
	output	core_pkg::data_t	wb_data,
	output	logic				halted
);

	import core_pkg::*;

	logic instr_capture;
	logic result_capture;
	logic pc_start;
	logic pc_advance;
	logic pc_load;
	logic writes_reg;
	logic branch_taken;
	logic is_halt;
	logic rf_we;

	pc_t pc;
	pc_t target;
	reg_idx_t raddr1;
	reg_idx_t raddr2;
	reg_idx_t dst;
	data_t rdata1;
	data_t rdata2;
	data_t result;

	//////////////////////////////
	// Control
	//////////////////////////////
	run_ctrl u_run_ctrl (
		.clock			(clock),
		.reset			(reset),
		.start			(start),
		.writes_reg		(writes_reg),
		.branch_taken	(branch_taken),
		.is_halt		(is_halt),
		.wb_ready		(wb_ready),
		.imem_re		(imem_re),
		.instr_capture	(instr_capture),
		.result_capture	(result_capture),
		.pc_start		(pc_start),
		.pc_advance		(pc_advance),
		.pc_load		(pc_load),
		.wb_valid		(wb_valid),
		.halted			(halted)
	);

	prog_counter #(
		.START_ADDR		(START_ADDR)
	) u_prog_counter (
		.clock			(clock),
		.reset			(reset),
		.pc_start		(pc_start),
		.pc_advance		(pc_advance),
		.pc_load		(pc_load),
		.target			(target),
		.pc				(pc)
	);

	assign imem_addr = pc;

	//////////////////////////////
	// Datapath
	//////////////////////////////
	// Register write happens on the handshake itself
	assign rf_we = wb_valid & wb_ready;

	reg_file u_reg_file (
		.clock			(clock),
		.reset			(reset),
		.we				(rf_we),
		.waddr			(dst),
		.wdata			(result),
		.raddr1			(raddr1),
		.raddr2			(raddr2),
		.rdata1			(rdata1),
		.rdata2			(rdata2)
	);

	exec_unit u_exec_unit (
		.clock			(clock),
		.reset			(reset),
		.instr_capture	(instr_capture),
		.result_capture	(result_capture),
		.imem_data		(imem_data),
		.rdata1			(rdata1),
		.rdata2			(rdata2),
		.raddr1			(raddr1),
		.raddr2			(raddr2),
		.dst			(dst),
		.result			(result),
		.target			(target),
		.writes_reg		(writes_reg),
		.branch_taken	(branch_taken),
		.is_halt		(is_halt)
	);

	assign wb_index = dst;
	assign wb_data = result;

	// Record payload holds while the consumer stalls
	assert property (@(posedge clock) disable iff (reset)
		wb_valid && !wb_ready |=> $stable(wb_index) && $stable(wb_data));

endmodule

//--- flist.f
design/core_pkg.sv
design/isa_pkg.sv
design/run_ctrl.sv
design/prog_counter.sv
design/reg_file.sv
design/exec_unit.sv
design/scalar_core.sv
tb/tb_checker.sv
tb/tb_top.sv

//--- run.sh
#!/bin/sh
# Build and run the scalar core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f flist.f -o tb_top_sim
sim_output=$(./obj_dir/tb_top_sim)
printf '%s\n' "$sim_output"
if printf '%s\n' "$sim_output" | grep -qx 'PASS: all tests'; then
	exit 0
fi
exit 1

//--- tb/core_tests.txt
# I <addr> <word> : instruction word at a memory address, hex
# E <index> <data> : expected write-back record in program order, hex
I 00 81001234  # MOVI r1, 0x1234
I 01 820000F0  # MOVI r2, 0x00F0
I 02 03120000  # ADD  r3, r1, r2
I 03 14210000  # SUB  r4, r2, r1
I 04 25120000  # AND  r5, r1, r2
I 05 36120000  # OR   r6, r1, r2
I 06 47120000  # XOR  r7, r1, r2
I 07 88000024  # MOVI r8, 0x24, shift amount 4 after masking
I 08 59180000  # SHL  r9, r1, r8
I 09 6A480000  # SHR  r10, r4, r8
I 0A 7B20FFFB  # ADDI r11, r2, -5
I 0B 80005555  # MOVI r0, 0x5555
I 0C 0C060000  # ADD  r12, r0, r6
I 0D 90110010  # BEQ  r1, r1, 0x10 taken
I 0E 8D00DEAD  # skipped
I 0F 8D00BEEF  # skipped
I 10 90120014  # BEQ  r1, r2, 0x14 not taken
I 11 8D0000AA  # MOVI r13, 0xAA
I 12 A0000015  # JMP  0x15
I 13 8E000BAD  # skipped
I 14 8E000F0F  # skipped
I 15 0FDC0000  # ADD  r15, r13, r12
I 16 F0000000  # no-op
I 17 B0000000  # HALT
I 18 8100FFFF  # never reached
E 1 00001234
E 2 000000F0
E 3 00001324
E 4 FFFFEEBC
E 5 00000030
E 6 000012F4
E 7 000012C4
E 8 00000024
E 9 00012340
E A 0FFFFEEB
E B 000000EB
E 0 00005555
E C 000012F4
E D 000000AA
E F 0000139E

//--- tb/tb_checker.sv
/*
 * Checker for the scalar core testbench. Samples the core mid-cycle,
 * compares every write-back transfer with the expected records of the
 * tests file and watches idle, back-pressure and halt behavior.
 */

`timescale 1ns/10ps

module tb_checker (
	input	logic				clock,
	input	logic				reset,
	input	logic				start,
	input	logic				imem_re,
	input	logic				wb_valid,
	input	logic				wb_ready,
	input	core_pkg::reg_idx_t	wb_index,
	input	core_pkg::data_t	wb_data,
	input	logic				halted,
	input	logic				done,
	output	int					errors
);

	import core_pkg::*;

	localparam string TESTS_FILE = "tb/core_tests.txt";

	reg_idx_t exp_index [$];
	data_t exp_data [$];
	int error_count = 0;
	int record_count = 0;
	logic started = 1'b0;
	logic halt_seen = 1'b0;
	logic held = 1'b0;
	reg_idx_t held_index;
	data_t held_data;

	assign errors = error_count;

	task automatic load_expected();
		int fd;
		int n;
		string line;
		logic [31:0] index;
		logic [31:0] value;
		fd = $fopen(TESTS_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open %s, no expected records", TESTS_FILE);
			error_count++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (line.len() > 2 && line.getc(0) == "E") begin
					n = $sscanf(line.substr(1, line.len() - 1), "%h %h", index, value);
					if (n == 2) begin
						exp_index.push_back(index[3:0]);
						exp_data.push_back(value);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic report_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
		error_count++;
	endtask

	task automatic check_record();
		if (record_count >= exp_index.size()) begin
			$display("Unexpected extra record for r%0d at %0t", wb_index, $time);
			error_count++;
		end else begin
			if (wb_index !== exp_index[record_count]) begin
				report_value("wb_index", exp_index[record_count], wb_index);
			end
			if (wb_data !== exp_data[record_count]) begin
				report_value("wb_data", exp_data[record_count], wb_data);
			end
		end
		record_count++;
	endtask

	initial begin
		load_expected();
	end

	// Sampled mid-cycle where inputs and outputs have settled
	always @(negedge clock) begin
		if (!reset && !started) begin
			if (imem_re !== 1'b0 || wb_valid !== 1'b0 || halted !== 1'b0) begin
				$display("Core active before start at %0t", $time);
				error_count++;
			end
		end
		if (start === 1'b1) begin
			started = 1'b1;
		end
		if (held) begin
			if (wb_valid !== 1'b1) begin
				$display("Record withdrawn before its transfer at %0t", $time);
				error_count++;
			end
			if (wb_index !== held_index) begin
				report_value("wb_index", held_index, wb_index);
			end
			if (wb_data !== held_data) begin
				report_value("wb_data", held_data, wb_data);
			end
		end
		held = (wb_valid === 1'b1) && (wb_ready !== 1'b1);
		held_index = wb_index;
		held_data = wb_data;
		if (halt_seen && halted !== 1'b1) begin
			$display("Core left the halted state at %0t", $time);
			error_count++;
		end
		if (halted === 1'b1) begin
			halt_seen = 1'b1;
		end
		if (halt_seen && (wb_valid !== 1'b0 || imem_re !== 1'b0)) begin
			$display("Core still fetching or writing after halt at %0t", $time);
			error_count++;
		end
		if (wb_valid === 1'b1 && wb_ready === 1'b1) begin
			check_record();
		end
	end

	always @(posedge done) begin
		if (record_count != exp_index.size()) begin
			$display("Only %0d of %0d expected records arrived", record_count,
				exp_index.size());
			error_count++;
		end
		$display("Checker: %0d of %0d records seen, %0d errors", record_count,
			exp_index.size(), error_count);
	end

endmodule

//--- tb/tb_top.sv
/*
 * Testbench top for the scalar core. Loads the program from the tests
 * file into an instruction memory model, pulses start, randomizes
 * wb_ready and ends the run once the core halts or the watchdog expires.
 */

`timescale 1ns/10ps

module tb_top;

	import core_pkg::*;

	localparam string TESTS_FILE = "tb/core_tests.txt";
	localparam int IMEM_WORDS = 256;
	localparam int CYCLES_PER_WORD = 20;
	localparam int WATCHDOG_SLACK = 100;
	localparam logic [31:0] SEED = 32'he7a8_2fc1;

	logic clock;
	logic reset;
	logic start;
	logic imem_re;
	pc_t imem_addr;
	instr_t imem_data;
	logic wb_valid;
	logic wb_ready;
	reg_idx_t wb_index;
	data_t wb_data;
	logic halted;
	logic done;
	int errors;

	instr_t imem [0:IMEM_WORDS-1];
	logic fetch_pending;
	pc_t fetch_addr;
	logic [31:0] rng_state;
	int word_count;
	int watchdog_cycles;

	scalar_core #(
		.START_ADDR	(8'h00)
	) u_scalar_core (
		.clock		(clock),
		.reset		(reset),
		.start		(start),
		.imem_re	(imem_re),
		.imem_addr	(imem_addr),
		.imem_data	(imem_data),
		.wb_valid	(wb_valid),
		.wb_ready	(wb_ready),
		.wb_index	(wb_index),
		.wb_data	(wb_data),
		.halted		(halted)
	);

	tb_checker u_tb_checker (
		.clock		(clock),
		.reset		(reset),
		.start		(start),
		.imem_re	(imem_re),
		.wb_valid	(wb_valid),
		.wb_ready	(wb_ready),
		.wb_index	(wb_index),
		.wb_data	(wb_data),
		.halted		(halted),
		.done		(done),
		.errors		(errors)
	);

	function automatic logic [31:0] next_random(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic load_program();
		int fd;
		int n;
		string line;
		logic [31:0] addr;
		logic [31:0] word;
		// Unwritten words decode as no-ops tagged with their own address
		for (int i = 0; i < IMEM_WORDS; i++) begin
			imem[i] = 32'hF000_0000 | i;
		end
		word_count = 0;
		fd = $fopen(TESTS_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open %s, no program loaded", TESTS_FILE);
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (line.len() > 2 && line.getc(0) == "I") begin
					n = $sscanf(line.substr(1, line.len() - 1), "%h %h", addr, word);
					if (n == 2) begin
						imem[addr[7:0]] = word;
						word_count++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	//////////////////////////////
	// Memory model and wb_ready
	//////////////////////////////
	always @(posedge clock) begin
		#2;
		if (fetch_pending === 1'b1) begin
			imem_data = imem[fetch_addr];
		end
		fetch_pending = imem_re;
		fetch_addr = imem_addr;
		rng_state = next_random(rng_state);
		wb_ready = (rng_state % 3) != 0;
	end

	initial begin
		reset = 1'b1;
		start = 1'b0;
		wb_ready = 1'b0;
		imem_data = '0;
		done = 1'b0;
		fetch_pending = 1'b0;
		fetch_addr = '0;
		rng_state = SEED;
		load_program();
		watchdog_cycles = CYCLES_PER_WORD * word_count + WATCHDOG_SLACK;
		fork
			begin
				repeat (watchdog_cycles) @(posedge clock);
				$display("Watchdog expired: core did not halt within %0d cycles",
					watchdog_cycles);
				done = 1'b1;
				#1;
				$display("FAIL: see errors above");
				$finish;
			end
		join_none
		repeat (5) @(posedge clock);
		#2;
		reset = 1'b0;
		// Idle stretch before start
		repeat (4) @(posedge clock);
		#2;
		start = 1'b1;
		@(posedge clock);
		#2;
		start = 1'b0;
		wait (halted === 1'b1);
		repeat (5) @(posedge clock);
		done = 1'b1;
		#1;
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule
